/* sim.f */
verilog/mob_pkg.sv
verilog/mob_square.sv
verilog/mob_adder_tree.sv
verilog/mob_control.sv
verilog/mob_evaluate.sv
dv/tb_clock.sv
dv/mob_evaluate_tb.sv

/* run.sh */
#!/bin/bash
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module mob_evaluate_tb -Mdir obj_dir -f sim.f \
   || { echo "Verilator build failed"; exit 1; }
output=$(./obj_dir/Vmob_evaluate_tb)
echo "$output"
echo "$output" | grep -qF "*** TEST PASSED ***" && exit 0 || exit 1

/* dv/mob_evaluate_tb.sv */
module mob_evaluate_tb;

   localparam int TIMEOUT_CYCLES = 50;

   logic            clk;
   logic            reset;
   logic            board_valid;
   mob_pkg::board_t board;
   logic            clear_eval;
   mob_pkg::score_t eval;
   logic            eval_valid;

   int error_count;
   int tests_run;
   int tests_failed;

   tb_clock clock_i (
      .clk (clk)
   );

   mob_evaluate mob_evaluate_i (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .board       (board),
      .clear_eval  (clear_eval),
      .eval        (eval),
      .eval_valid  (eval_valid)
   );

   function automatic mob_pkg::board_t place(input mob_pkg::board_t b, input int r, input int c,
                                             input mob_pkg::piece_t p);
      mob_pkg::board_t result;
      result = b;
      result[(r * 8 + c) * mob_pkg::PIECE_WIDTH +: mob_pkg::PIECE_WIDTH] = p;
      return result;
   endfunction

   function automatic logic [3:0] piece_at(input mob_pkg::board_t b, input int r, input int c);
      return b[(r * 8 + c) * mob_pkg::PIECE_WIDTH +: mob_pkg::PIECE_WIDTH];
   endfunction

   // Knight targets that are empty or enemy
   function automatic int knight_moves(input mob_pkg::board_t b, input int r, input int c,
                                       input logic black);
      int         jump_r [8];
      int         jump_c [8];
      int         count;
      int         tr;
      int         tc;
      logic [3:0] p;
      jump_r = '{2, 2, -2, -2, 1, 1, -1, -1};
      jump_c = '{1, -1, 1, -1, 2, -2, 2, -2};
      count  = 0;
      for (int k = 0; k < 8; k++)
      begin
         tr = r + jump_r[k];
         tc = c + jump_c[k];
         if (tr >= 0 && tr < 8 && tc >= 0 && tc < 8)
         begin
            p = piece_at(b, tr, tc);
            if (p == 4'h0 || p[3] != black)
               count++;
         end
      end
      return count;
   endfunction

   function automatic int rook_moves(input mob_pkg::board_t b, input int r, input int c,
                                     input logic black);
      int         step_r [4];
      int         step_c [4];
      int         count;
      int         tr;
      int         tc;
      logic       blocked;
      logic [3:0] p;
      step_r = '{1, -1, 0, 0};
      step_c = '{0, 0, 1, -1};
      count  = 0;
      for (int d = 0; d < 4; d++)
      begin
         tr      = r;
         tc      = c;
         blocked = 1'b0;
         while (!blocked)
         begin
            tr = tr + step_r[d];
            tc = tc + step_c[d];
            if (tr < 0 || tr > 7 || tc < 0 || tc > 7)
               blocked = 1'b1;
            else
            begin
               p = piece_at(b, tr, tc);
               if (p == 4'h0)
                  count++;
               else
               begin
                  if (p[3] != black)
                     count++; // Capture ends the slide
                  blocked = 1'b1;
               end
            end
         end
      end
      return count;
   endfunction

   // Reference mobility score of a whole board
   function automatic mob_pkg::score_t reference_score(input mob_pkg::board_t b);
      mob_pkg::score_t total;
      logic [3:0]      p;
      int              mg_sum;
      int              eg_sum;
      int              mg;
      int              eg;
      int              moves;
      mg_sum = 0;
      eg_sum = 0;
      for (int sq = 0; sq < 64; sq++)
      begin
         p  = piece_at(b, sq / 8, sq % 8);
         mg = 0;
         eg = 0;
         if (p == mob_pkg::WHITE_KNIGHT || p == mob_pkg::BLACK_KNIGHT)
         begin
            moves = knight_moves(b, sq / 8, sq % 8, p[3]);
            mg    = moves * int'(mob_pkg::KNIGHT_MG_WEIGHT);
            eg    = moves * int'(mob_pkg::KNIGHT_EG_WEIGHT);
         end
         else if (p == mob_pkg::WHITE_ROOK || p == mob_pkg::BLACK_ROOK)
         begin
            moves = rook_moves(b, sq / 8, sq % 8, p[3]);
            mg    = moves * int'(mob_pkg::ROOK_MG_WEIGHT);
            eg    = moves * int'(mob_pkg::ROOK_EG_WEIGHT);
         end
         if (p[3])
         begin
            mg_sum = mg_sum - mg;
            eg_sum = eg_sum - eg;
         end
         else
         begin
            mg_sum = mg_sum + mg;
            eg_sum = eg_sum + eg;
         end
      end
      total.mg = mob_pkg::EVAL_WIDTH'(mg_sum);
      total.eg = mob_pkg::EVAL_WIDTH'(eg_sum);
      return total;
   endfunction

   task automatic stop_on_timeout(input string what);
      $display("TIMEOUT: %s", what);
      $display("*** TEST FAILED ***");
      $finish;
   endtask

   task automatic check_score(input string name, input mob_pkg::score_t expected,
                              input mob_pkg::score_t actual);
      if (actual.mg !== expected.mg)
      begin
         $display("CHECK FAILED %s mg: expected %0d, actual %0d", name, expected.mg, actual.mg);
         error_count++;
      end
      if (actual.eg !== expected.eg)
      begin
         $display("CHECK FAILED %s eg: expected %0d, actual %0d", name, expected.eg, actual.eg);
         error_count++;
      end
   endtask

   // Returns the sum and the edges from start edge to eval_valid
   task automatic evaluate_board(input string name, input mob_pkg::board_t b,
                                 output mob_pkg::score_t result, output int latency);
      int edges;
      @(negedge clk);
      board       = b;
      board_valid = 1'b0;
      @(negedge clk);
      board_valid = 1'b1;
      edges       = 0;
      while (!eval_valid && edges < TIMEOUT_CYCLES)
      begin
         @(negedge clk);
         edges++;
      end
      if (!eval_valid)
         stop_on_timeout({name, ": eval_valid never rose"});
      result      = eval;
      latency     = edges - 1;
      board_valid = 1'b0;
   endtask

   task automatic clear_result(input string name);
      int cycles;
      clear_eval = 1'b1;
      cycles     = 0;
      while (eval_valid && cycles < TIMEOUT_CYCLES)
      begin
         @(negedge clk);
         cycles++;
      end
      if (eval_valid)
         stop_on_timeout({name, ": eval_valid did not fall after clear_eval"});
      clear_eval = 1'b0;
   endtask

   task automatic run_board(input string name, input mob_pkg::board_t b,
                            input mob_pkg::score_t expected);
      mob_pkg::score_t result;
      int              latency;
      evaluate_board(name, b, result, latency);
      check_score(name, expected, result);
      clear_result(name);
   endtask

   task automatic finish_test(input string name, input int errors_before);
      tests_run++;
      if (error_count == errors_before)
         $display("PASS  %s", name);
      else
      begin
         $display("FAIL  %s", name);
         tests_failed++;
      end
   endtask

   task automatic reset_and_empty();
      int errors_before;
      errors_before = error_count;
      if (eval_valid !== 1'b0)
      begin
         $display("CHECK FAILED reset eval_valid: expected 0, actual %b", eval_valid);
         error_count++;
      end
      run_board("empty board", '0, '{mg: 16'sd0, eg: 16'sd0});
      finish_test("reset and empty board", errors_before);
   endtask

   task automatic lone_knights();
      int errors_before;
      errors_before = error_count;
      run_board("knight d4", place('0, 3, 3, mob_pkg::WHITE_KNIGHT), '{mg: 16'sd32, eg: 16'sd24});
      run_board("knight a1", place('0, 0, 0, mob_pkg::WHITE_KNIGHT), '{mg: 16'sd8, eg: 16'sd6});
      finish_test("lone white knights", errors_before);
   endtask

   task automatic rook_rays();
      mob_pkg::board_t b;
      int              errors_before;
      errors_before = error_count;
      b = place('0, 0, 0, mob_pkg::WHITE_ROOK);
      b = place(b, 2, 0, mob_pkg::WHITE_PAWN); // Own blocker on a3
      b = place(b, 0, 2, mob_pkg::BLACK_PAWN); // Capture on c1
      run_board("rook a1", b, '{mg: 16'sd6, eg: 16'sd15});
      finish_test("rook rays", errors_before);
   endtask

   task automatic colour_sign();
      mob_pkg::board_t white_side;
      mob_pkg::board_t black_side;
      int              errors_before;
      errors_before = error_count;
      white_side = place('0, 3, 3, mob_pkg::WHITE_KNIGHT);
      white_side = place(white_side, 0, 0, mob_pkg::WHITE_ROOK);
      white_side = place(white_side, 2, 0, mob_pkg::WHITE_PAWN);
      white_side = place(white_side, 0, 2, mob_pkg::BLACK_PAWN);
      // Mirror image across the board middle
      black_side = place('0, 4, 3, mob_pkg::BLACK_KNIGHT);
      black_side = place(black_side, 7, 0, mob_pkg::BLACK_ROOK);
      black_side = place(black_side, 5, 0, mob_pkg::BLACK_PAWN);
      black_side = place(black_side, 7, 2, mob_pkg::WHITE_PAWN);
      run_board("black alone", black_side, '{mg: -16'sd38, eg: -16'sd39});
      run_board("mirrored mix", white_side | black_side, '{mg: 16'sd0, eg: 16'sd0});
      finish_test("colour sign and mixing", errors_before);
   endtask

   task automatic latency_and_clear();
      mob_pkg::board_t b;
      mob_pkg::score_t result;
      int              latency;
      int              errors_before;
      errors_before = error_count;
      b = place('0, 3, 3, mob_pkg::WHITE_KNIGHT);
      evaluate_board("latency", b, result, latency);
      if (latency != mob_pkg::EVAL_LATENCY)
      begin
         $display("CHECK FAILED latency edges: expected %0d, actual %0d",
                  mob_pkg::EVAL_LATENCY, latency);
         error_count++;
      end
      check_score("latency", '{mg: 16'sd32, eg: 16'sd24}, result);
      // A fresh edge while waiting for clear
      @(negedge clk);
      board_valid = 1'b1;
      @(negedge clk);
      board_valid = 1'b0;
      repeat (4)
      begin
         @(negedge clk);
         if (eval_valid !== 1'b1)
         begin
            $display("CHECK FAILED latency hold eval_valid: expected 1, actual %b", eval_valid);
            error_count++;
         end
         check_score("latency hold", '{mg: 16'sd32, eg: 16'sd24}, eval);
      end
      clear_result("latency");
      repeat (mob_pkg::EVAL_LATENCY + 3)
      begin
         @(negedge clk);
         if (eval_valid !== 1'b0)
         begin
            $display("CHECK FAILED ignored edge eval_valid: expected 0, actual %b", eval_valid);
            error_count++;
         end
      end
      run_board("after clear", place('0, 0, 0, mob_pkg::WHITE_KNIGHT),
                '{mg: 16'sd8, eg: 16'sd6});
      finish_test("exact latency and clear", errors_before);
   endtask

   task automatic random_boards();
      mob_pkg::piece_t choices [6];
      mob_pkg::board_t b;
      int              pick;
      int              errors_before;
      errors_before = error_count;
      choices = '{mob_pkg::WHITE_KNIGHT, mob_pkg::WHITE_ROOK, mob_pkg::WHITE_PAWN,
                  mob_pkg::BLACK_KNIGHT, mob_pkg::BLACK_ROOK, mob_pkg::BLACK_PAWN};
      for (int n = 0; n < 20; n++)
      begin
         b = '0;
         for (int sq = 0; sq < 64; sq++)
         begin
            pick = $urandom % 16;
            if (pick >= 10) // Roughly 6 in 16 squares occupied
               b = place(b, sq / 8, sq % 8, choices[pick - 10]);
         end
         run_board($sformatf("random board %0d", n), b, reference_score(b));
      end
      finish_test("random boards", errors_before);
   endtask

   initial
   begin
      reset        = 1'b1;
      board_valid  = 1'b0;
      board        = '0;
      clear_eval   = 1'b0;
      error_count  = 0;
      tests_run    = 0;
      tests_failed = 0;
      void'($urandom(65442));
      repeat (5) @(posedge clk); // Five edges in reset
      @(negedge clk);
      reset = 1'b0;
      @(negedge clk);

      reset_and_empty();
      lone_knights();
      rook_rays();
      colour_sign();
      latency_and_clear();
      random_boards();

      $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
               error_count);
      if (error_count == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

/* dv/tb_clock.sv */
module tb_clock (
   output logic clk
);

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk; // Period 100
   end

endmodule

/* verilog/mob_evaluate.sv */
module mob_evaluate (
   input  logic            clk,
   input  logic            reset,
   input  logic            board_valid,
   input  mob_pkg::board_t board,
   input  logic            clear_eval,
   output mob_pkg::score_t eval,
   output logic            eval_valid
);

   mob_pkg::score_t scores [mob_pkg::SQUARE_COUNT]; // One per square

   for (genvar row = 0; row < 8; row++)
   begin : row_blk
      for (genvar col = 0; col < 8; col++)
      begin : col_blk
         mob_square #(
            .ROW (row),
            .COL (col)
         ) square_i (
            .clk   (clk),
            .board (board),
            .score (scores[row * 8 + col])
         );
      end
   end

   mob_adder_tree adder_tree_i (
      .clk    (clk),
      .scores (scores),
      .sum    (eval)
   );

   mob_control control_i (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .clear_eval  (clear_eval),
      .eval_valid  (eval_valid)
   );

endmodule

/* verilog/mob_control.sv */
module mob_control (
   input  logic clk,
   input  logic reset,
   input  logic board_valid,
   input  logic clear_eval,
   output logic eval_valid
);

   typedef logic [$clog2(mob_pkg::EVAL_LATENCY + 1) - 1:0] latency_t;

   mob_pkg::mob_state_t state;
   logic                board_valid_r;
   latency_t            latency;
   logic                start;

   assign start = board_valid && !board_valid_r; // Rising edge of board_valid

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state         <= mob_pkg::STATE_IDLE;
         eval_valid    <= 1'b0;
         board_valid_r <= 1'b0;
         latency       <= '0;
      end
      else
      begin
         board_valid_r <= board_valid;
         case (state)
            mob_pkg::STATE_IDLE:
            begin
               latency <= latency_t'(1);
               if (start)
                  state <= mob_pkg::STATE_LATENCY;
            end
            mob_pkg::STATE_LATENCY:
            begin
               latency <= latency + 1'b1;
               if (latency == latency_t'(mob_pkg::EVAL_LATENCY))
               begin
                  eval_valid <= 1'b1; // Sum lands on this edge
                  state      <= mob_pkg::STATE_WAIT_CLEAR;
               end
            end
            mob_pkg::STATE_WAIT_CLEAR:
            begin
               if (clear_eval)
               begin
                  eval_valid <= 1'b0;
                  state      <= mob_pkg::STATE_IDLE;
               end
            end
            default:
               state <= mob_pkg::STATE_IDLE;
         endcase
      end
   end

endmodule

/* verilog/mob_adder_tree.sv */
module mob_adder_tree (
   input  logic            clk,
   input  mob_pkg::score_t scores [mob_pkg::SQUARE_COUNT],
   output mob_pkg::score_t sum
);

   mob_pkg::score_t stage1 [mob_pkg::SQUARE_COUNT / 4];
   mob_pkg::score_t stage2 [mob_pkg::SQUARE_COUNT / 16];

   function automatic mob_pkg::score_t add4(input mob_pkg::score_t a, input mob_pkg::score_t b,
                                           input mob_pkg::score_t c, input mob_pkg::score_t d);
      mob_pkg::score_t result;
      result.mg = a.mg + b.mg + c.mg + d.mg;
      result.eg = a.eg + b.eg + c.eg + d.eg;
      return result;
   endfunction

   // 64 to 16
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < mob_pkg::SQUARE_COUNT / 4; i++)
      begin
         stage1[i] <= add4(scores[i*4], scores[i*4+1], scores[i*4+2], scores[i*4+3]);
      end
   end

   // 16 to 4
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < mob_pkg::SQUARE_COUNT / 16; i++)
      begin
         stage2[i] <= add4(stage1[i*4], stage1[i*4+1], stage1[i*4+2], stage1[i*4+3]);
      end
   end

   always_ff @(posedge clk)
   begin
      sum <= add4(stage2[0], stage2[1], stage2[2], stage2[3]); // Final sum
   end

endmodule

/* verilog/mob_square.sv */
module mob_square #(
   parameter int ROW = 0,
   parameter int COL = 0
) (
   input  logic            clk,
   input  mob_pkg::board_t board,
   output mob_pkg::score_t score
);

   localparam int SQUARE = ROW * 8 + COL;

   mob_pkg::piece_t                      piece;
   logic                                 is_black;
   logic [mob_pkg::EVAL_WIDTH-1:0]       knight_moves;
   logic [mob_pkg::EVAL_WIDTH-1:0]       rook_moves;
   logic [mob_pkg::EVAL_WIDTH-1:0]       moves;
   logic signed [mob_pkg::EVAL_WIDTH-1:0] mg_weight;
   logic signed [mob_pkg::EVAL_WIDTH-1:0] eg_weight;
   logic signed [mob_pkg::EVAL_WIDTH-1:0] mg_value;
   logic signed [mob_pkg::EVAL_WIDTH-1:0] eg_value;
   mob_pkg::score_t                      score_next;

   // Empty or enemy square inside the board
   function automatic logic reachable(input mob_pkg::board_t b, input int r, input int c,
                                      input logic black);
      logic [mob_pkg::PIECE_WIDTH-1:0] target;
      if (r < 0 || r > 7 || c < 0 || c > 7)
         return 1'b0;
      target = b[(r * 8 + c) * mob_pkg::PIECE_WIDTH +: mob_pkg::PIECE_WIDTH];
      return target == mob_pkg::EMPTY || target[mob_pkg::PIECE_WIDTH-1] != black;
   endfunction

   function automatic logic [mob_pkg::EVAL_WIDTH-1:0] knight_count(input mob_pkg::board_t b,
                                                                  input logic black);
      logic [mob_pkg::EVAL_WIDTH-1:0] count;
      int                             dc;
      count = '0;
      for (int dr = -2; dr <= 2; dr++)
      begin
         if (dr != 0)
         begin
            dc = 3 - (dr < 0 ? -dr : dr); // (1,2) or (2,1) jumps
            if (reachable(b, ROW + dr, COL + dc, black))
               count = count + 1'b1;
            if (reachable(b, ROW + dr, COL - dc, black))
               count = count + 1'b1;
         end
      end
      return count;
   endfunction

   // Slide until first blocker, enemy blocker counts
   function automatic logic [mob_pkg::EVAL_WIDTH-1:0] ray_count(input mob_pkg::board_t b,
                                                               input int dr, input int dc,
                                                               input logic black);
      logic [mob_pkg::EVAL_WIDTH-1:0]  count;
      logic [mob_pkg::PIECE_WIDTH-1:0] target;
      logic                            open;
      int                              r;
      int                              c;
      count = '0;
      open  = 1'b1;
      r     = ROW;
      c     = COL;
      for (int step = 1; step < 8; step++)
      begin
         r = r + dr;
         c = c + dc;
         if (open && r >= 0 && r < 8 && c >= 0 && c < 8)
         begin
            target = b[(r * 8 + c) * mob_pkg::PIECE_WIDTH +: mob_pkg::PIECE_WIDTH];
            if (target == mob_pkg::EMPTY)
               count = count + 1'b1;
            else
            begin
               if (target[mob_pkg::PIECE_WIDTH-1] != black)
                  count = count + 1'b1;
               open = 1'b0;
            end
         end
      end
      return count;
   endfunction

   always_comb
   begin
      piece    = mob_pkg::piece_t'(board[SQUARE * mob_pkg::PIECE_WIDTH +: mob_pkg::PIECE_WIDTH]);
      is_black = piece[mob_pkg::PIECE_WIDTH-1];

      knight_moves = knight_count(board, is_black);
      rook_moves   = ray_count(board, 1, 0, is_black) + ray_count(board, -1, 0, is_black)
                   + ray_count(board, 0, 1, is_black) + ray_count(board, 0, -1, is_black);

      case (piece)
         mob_pkg::WHITE_KNIGHT, mob_pkg::BLACK_KNIGHT:
         begin
            moves     = knight_moves;
            mg_weight = mob_pkg::KNIGHT_MG_WEIGHT;
            eg_weight = mob_pkg::KNIGHT_EG_WEIGHT;
         end
         mob_pkg::WHITE_ROOK, mob_pkg::BLACK_ROOK:
         begin
            moves     = rook_moves;
            mg_weight = mob_pkg::ROOK_MG_WEIGHT;
            eg_weight = mob_pkg::ROOK_EG_WEIGHT;
         end
         default:
         begin
            moves     = '0;
            mg_weight = '0;
            eg_weight = '0;
         end
      endcase

      mg_value = $signed(moves) * mg_weight;
      eg_value = $signed(moves) * eg_weight;

      score_next.mg = is_black ? -mg_value : mg_value; // Black scores negative
      score_next.eg = is_black ? -eg_value : eg_value;
   end

   always_ff @(posedge clk)
   begin
      score <= score_next;
   end

endmodule

/* verilog/mob_pkg.sv */
package mob_pkg;

   localparam int EVAL_WIDTH   = 16;
   localparam int SQUARE_COUNT = 64;
   localparam int PIECE_WIDTH  = 4;
   localparam int BOARD_WIDTH  = SQUARE_COUNT * PIECE_WIDTH;

   // Edges from start edge to final sum
   localparam int EVAL_LATENCY = 3;

   // Per-move weights
   localparam logic signed [EVAL_WIDTH-1:0] KNIGHT_MG_WEIGHT = EVAL_WIDTH'(4);
   localparam logic signed [EVAL_WIDTH-1:0] KNIGHT_EG_WEIGHT = EVAL_WIDTH'(3);
   localparam logic signed [EVAL_WIDTH-1:0] ROOK_MG_WEIGHT   = EVAL_WIDTH'(2);
   localparam logic signed [EVAL_WIDTH-1:0] ROOK_EG_WEIGHT   = EVAL_WIDTH'(5);

   // Top bit set for black
   typedef enum logic [PIECE_WIDTH-1:0] {
      EMPTY        = 4'h0,
      WHITE_PAWN   = 4'h1,
      WHITE_KNIGHT = 4'h2,
      WHITE_BISHOP = 4'h3,
      WHITE_ROOK   = 4'h4,
      WHITE_QUEEN  = 4'h5,
      WHITE_KING   = 4'h6,
      BLACK_PAWN   = 4'h9,
      BLACK_KNIGHT = 4'ha,
      BLACK_BISHOP = 4'hb,
      BLACK_ROOK   = 4'hc,
      BLACK_QUEEN  = 4'hd,
      BLACK_KING   = 4'he
   } piece_t;

   // Square r*8+c at bits [PIECE_WIDTH*(r*8+c) +: PIECE_WIDTH]
   typedef logic [BOARD_WIDTH-1:0] board_t;

   typedef struct packed {
      logic signed [EVAL_WIDTH-1:0] mg;
      logic signed [EVAL_WIDTH-1:0] eg;
   } score_t;

   typedef enum logic [1:0] {
      STATE_IDLE       = 2'd0,
      STATE_LATENCY    = 2'd1,
      STATE_WAIT_CLEAR = 2'd2
   } mob_state_t;

endpackage
